// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# Output goes to the terminal and to grep, which sets the exit status
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
logic/sta_pkg.sv
logic/sta_result_if.sv
logic/operand_skew.sv
logic/sta_pe.sv
logic/sta_array.sv
logic/output_coordinator.sv
logic/sta_top.sv
dv/tb_clk_gen.sv
dv/tb_top.sv

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int PERIOD = 10  // Clock period in time units
)(
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Free-running clock, first rising edge at PERIOD/2
  always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== dv/tb_top.sv ====
module tb_top
  import sta_pkg::*;
;

  localparam int ROWS = 4;
  localparam int COLS = 4;
  localparam int NPE  = ROWS * COLS;
  localparam int MAX_N = 64;
  localparam int NUM_CH = 16;
  localparam int N_BITS = $clog2(MAX_N + 1);
  localparam int CH_BITS = $clog2(NUM_CH + 1);

  typedef struct {
    int                 tgt;   // Non-stall cycle count when valid is due
    acc_t               data;
    logic [N_BITS-1:0]  row;
    logic [N_BITS-1:0]  col;
    logic [CH_BITS-1:0] ch;
  } exp_t;

  logic               clk;
  logic               reset;
  logic               stall;
  logic               cmd_valid;
  logic [N_BITS-1:0]  mat_size;
  logic [N_BITS-1:0]  pos_row;
  logic [N_BITS-1:0]  pos_col;
  logic [CH_BITS-1:0] channel;
  opnd_pack_t         west_in  [ROWS];
  opnd_pack_t         north_in [COLS];
  logic               cmd_ready;
  logic               idle;
  logic               res_valid   [NPE];
  logic [N_BITS-1:0]  res_row     [NPE];
  logic [N_BITS-1:0]  res_col     [NPE];
  logic [CH_BITS-1:0] res_channel [NPE];
  acc_t               res_data    [NPE];

  logic [31:0] lcg_state = 32'h94d1;
  int          ns = 0;           // Non-stall edges seen by the model
  logic        drv_stall = 1'b0;  // Copies of what the stimulus drove this cycle
  logic        drv_accept = 1'b0;

  // Current block as presented upstream
  opnd_pack_t a_pk [ROWS][16];
  opnd_pack_t b_pk [COLS][16];
  int         pend_c;
  exp_t       pend [NPE];

  // One queue of outstanding results per PE
  exp_t               exp_q [NPE][$];
  logic               exp_valid [NPE];
  acc_t               exp_data  [NPE];
  logic [N_BITS-1:0]  exp_row   [NPE];
  logic [N_BITS-1:0]  exp_col   [NPE];
  logic [CH_BITS-1:0] exp_ch    [NPE];
  logic               exp_idle  = 1'b1;
  logic               exp_ready = 1'b1;

  tb_clk_gen #(.PERIOD(10)) u_clk (.clk(clk));

  sta_top #(
    .ROWS   (ROWS),
    .COLS   (COLS),
    .NUM_CH (NUM_CH),
    .MAX_N  (MAX_N)
  ) u_dut (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .cmd_valid   (cmd_valid),
    .mat_size    (mat_size),
    .pos_row     (pos_row),
    .pos_col     (pos_col),
    .channel     (channel),
    .west_in     (west_in),
    .north_in    (north_in),
    .cmd_ready   (cmd_ready),
    .idle        (idle),
    .res_valid   (res_valid),
    .res_row     (res_row),
    .res_col     (res_col),
    .res_channel (res_channel),
    .res_data    (res_data)
  );

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_value(input string name, input longint got, input longint want);
    $display("Mismatch at time %0t: %s got %0d expected %0d", $time, name, got, want);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic fail_plain(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // Reference model advances once per clock edge
  always @(posedge clk) begin
    exp_t e;
    if (reset) begin
      ns = 0;
      for (int k = 0; k < NPE; k++) begin
        exp_q[k].delete();
      end
    end else if (!drv_stall) begin
      for (int k = 0; k < NPE; k++) begin
        if (exp_q[k].size() > 0 && exp_q[k][0].tgt == ns) begin
          exp_q[k].pop_front();  // Retired
        end
      end
      if (drv_accept) begin
        for (int i = 0; i < ROWS; i++) begin
          for (int j = 0; j < COLS; j++) begin
            e = pend[i*COLS+j];
            e.tgt = ns + i + j + pend_c;  // Cycle i+j+C after acceptance
            exp_q[i*COLS+j].push_back(e);
          end
        end
      end
      ns++;
    end
    exp_idle = 1'b1;
    for (int k = 0; k < NPE; k++) begin
      exp_valid[k] = exp_q[k].size() > 0 && exp_q[k][0].tgt == ns;
      if (exp_q[k].size() > 0) begin
        exp_idle   = 1'b0;
        exp_data[k] = exp_q[k][0].data;
        exp_row[k]  = exp_q[k][0].row;
        exp_col[k]  = exp_q[k][0].col;
        exp_ch[k]   = exp_q[k][0].ch;
      end
    end
    // PE(0,0) busy unless in its final cycle
    exp_ready = !(exp_q[0].size() > 0 && exp_q[0][0].tgt != ns);
  end

  a_idle: assert property (@(posedge clk) disable iff (reset) idle == exp_idle)
    else fail_value("idle", $sampled(idle), $sampled(exp_idle));
  a_ready: assert property (@(posedge clk) disable iff (reset) cmd_ready == exp_ready)
    else fail_value("cmd_ready", $sampled(cmd_ready), $sampled(exp_ready));

  for (genvar k = 0; k < NPE; k++) begin : g_chk
    a_valid: assert property (@(posedge clk) disable iff (reset) res_valid[k] == exp_valid[k])
      else fail_value($sformatf("res_valid[%0d]", k), $sampled(res_valid[k]),
                      $sampled(exp_valid[k]));
    a_data: assert property (@(posedge clk) disable iff (reset)
                             exp_valid[k] |-> res_data[k] == exp_data[k])
      else fail_value($sformatf("res_data[%0d]", k), $sampled(res_data[k]),
                      $sampled(exp_data[k]));
    a_row: assert property (@(posedge clk) disable iff (reset)
                            exp_valid[k] |-> res_row[k] == exp_row[k])
      else fail_value($sformatf("res_row[%0d]", k), $sampled(res_row[k]), $sampled(exp_row[k]));
    a_col: assert property (@(posedge clk) disable iff (reset)
                            exp_valid[k] |-> res_col[k] == exp_col[k])
      else fail_value($sformatf("res_col[%0d]", k), $sampled(res_col[k]), $sampled(exp_col[k]));
    a_ch: assert property (@(posedge clk) disable iff (reset)
                           exp_valid[k] |-> res_channel[k] == exp_ch[k])
      else fail_value($sformatf("res_channel[%0d]", k), $sampled(res_channel[k]),
                      $sampled(exp_ch[k]));
  end

  // Random block with zero lanes past mat_size and its expected results per PE
  task automatic make_block();
    int   n;
    int   sum;
    int   idx;
    n = 3 + int'(rand_next() % 62);
    pend_c = (n + 3) / 4;
    mat_size = N_BITS'(n);
    pos_row  = N_BITS'(rand_next() % 61);  // Leaves room for the +3 offset
    pos_col  = N_BITS'(rand_next() % 61);
    channel  = CH_BITS'(rand_next() % NUM_CH);
    for (int k = 0; k < pend_c; k++) begin
      for (int l = 0; l < LANES; l++) begin
        idx = k * LANES + l;
        for (int r = 0; r < ROWS; r++) begin
          a_pk[r][k][l*DATA_W +: DATA_W] = (idx < n) ? DATA_W'(rand_next() >> 16) : '0;
        end
        for (int c = 0; c < COLS; c++) begin
          b_pk[c][k][l*DATA_W +: DATA_W] = (idx < n) ? DATA_W'(rand_next() >> 16) : '0;
        end
      end
    end
    for (int i = 0; i < ROWS; i++) begin
      for (int j = 0; j < COLS; j++) begin
        sum = 0;
        for (int k = 0; k < pend_c; k++) begin
          for (int l = 0; l < LANES; l++) begin
            sum += int'(operand_t'(a_pk[i][k][l*DATA_W +: DATA_W]))
                 * int'(operand_t'(b_pk[j][k][l*DATA_W +: DATA_W]));
          end
        end
        pend[i*COLS+j].data = sum;
        pend[i*COLS+j].row  = pos_row + N_BITS'(i);
        pend[i*COLS+j].col  = pos_col + N_BITS'(j);
        pend[i*COLS+j].ch   = channel;
      end
    end
  endtask

  task automatic drive_packs(input int k, input bit zero);
    for (int r = 0; r < ROWS; r++) begin
      west_in[r] = zero ? '0 : a_pk[r][k];
    end
    for (int c = 0; c < COLS; c++) begin
      north_in[c] = zero ? '0 : b_pk[c][k];
    end
  endtask

  task automatic wait_ready();
    int spins;
    for (spins = 0; spins < 200; spins++) begin
      @(negedge clk);
      cmd_valid  = 1'b0;
      drv_accept = 1'b0;
      stall      = 1'b0;
      drv_stall  = 1'b0;
      drive_packs(0, 1'b1);
      if (cmd_ready) break;
    end
    if (spins == 200) fail_plain("cmd_ready never went high");
  endtask

  task automatic send_block(input int stall_pct, input bit back_to_back);
    int k;
    int spins;
    if (back_to_back) begin
      @(negedge clk);  // Cycle right after the previous block's last pack
      if (!cmd_ready) fail_plain("cmd_ready low on the cycle after the last pack");
    end else begin
      wait_ready();
    end
    make_block();  // New command fields appear on the falling edge
    cmd_valid  = 1'b1;
    stall      = 1'b0;
    drv_stall  = 1'b0;
    drv_accept = 1'b1;
    drive_packs(0, 1'b0);
    @(posedge clk);
    k = 1;
    spins = 0;
    while (k < pend_c) begin
      @(negedge clk);
      cmd_valid  = 1'b0;
      drv_accept = 1'b0;
      stall      = (rand_next() % 100) < stall_pct;
      drv_stall  = stall;
      drive_packs(k, 1'b0);  // Held while stalled
      @(posedge clk);
      if (!drv_stall) k++;
      spins++;
      if (spins > 1000) fail_plain("operand packs not consumed in time");
    end
  endtask

  task automatic wait_idle(input int stall_pct);
    int spins;
    for (spins = 0; spins < 1000; spins++) begin
      @(negedge clk);
      cmd_valid  = 1'b0;
      drv_accept = 1'b0;
      drive_packs(0, 1'b1);
      if (idle && exp_idle) begin
        stall     = 1'b0;
        drv_stall = 1'b0;
        break;
      end
      stall     = (rand_next() % 100) < stall_pct;  // Stalls during the drain too
      drv_stall = stall;
    end
    if (spins == 1000) fail_plain("array did not return to idle");
  endtask

  initial begin
    reset     = 1'b1;
    stall     = 1'b0;
    cmd_valid = 1'b0;
    mat_size  = '0;
    pos_row   = '0;
    pos_col   = '0;
    channel   = '0;
    drive_packs(0, 1'b1);
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (2) @(posedge clk);

    send_block(0, 1'b0);  // Single block without stalls
    wait_idle(0);
    repeat (3) begin
      send_block(0, 1'b0);
      send_block(0, 1'b1);  // Second block while the first drains
      wait_idle(0);
    end
    repeat (3) begin
      send_block(25, 1'b0);
      send_block(25, 1'b1);
      wait_idle(25);
    end
    send_block(30, 1'b0);
    repeat (8) send_block(30, rand_next() % 2 == 1);
    wait_idle(30);
    repeat (3) @(posedge clk);

    $display("Test passed");
    $finish;
  end

endmodule

// ==== logic/operand_skew.sv ====
module operand_skew
  import sta_pkg::*;
#(
  parameter int ROWS = 4,  // PE rows
  parameter int COLS = 4   // PE columns
)(
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,              // Hold every stage
  input  opnd_pack_t west_in   [ROWS],   // Unskewed packs per row
  input  opnd_pack_t north_in  [COLS],   // Unskewed packs per column
  output opnd_pack_t west_out  [ROWS],   // Row i delayed by i+1
  output opnd_pack_t north_out [COLS]    // Column j delayed by j+1
);

  // Rows and columns share one set of chains
  // Chains 0..ROWS-1 are rows, the rest are columns
  localparam int NUM_CHAINS = ROWS + COLS;

  opnd_pack_t chain_in  [NUM_CHAINS];
  opnd_pack_t chain_out [NUM_CHAINS];

  for (genvar i = 0; i < ROWS; i++) begin : g_west
    assign chain_in[i] = west_in[i];
    assign west_out[i] = chain_out[i];
  end

  for (genvar j = 0; j < COLS; j++) begin : g_north
    assign chain_in[ROWS+j] = north_in[j];
    assign north_out[j]     = chain_out[ROWS+j];
  end

  for (genvar n = 0; n < NUM_CHAINS; n++) begin : g_chain
    // Row i gets i+1 stages, column j gets j+1
    localparam int DEPTH = (n < ROWS) ? n + 1 : n - ROWS + 1;

    opnd_pack_t stage [DEPTH];

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int k = 0; k < DEPTH; k++) begin
          stage[k] <= '0;  // Zero packs add nothing to a PE
        end
      end else if (!stall) begin
        stage[0] <= chain_in[n];
        for (int k = 1; k < DEPTH; k++) begin
          stage[k] <= stage[k-1];
        end
      end
    end

    assign chain_out[n] = stage[DEPTH-1];  // Oldest stage feeds the grid edge
  end

endmodule

// ==== logic/output_coordinator.sv ====
module output_coordinator #(
  parameter int ROWS    = 4,                    // PE rows
  parameter int COLS    = 4,                    // PE columns
  parameter int NUM_CH  = 16,                   // Max channel count
  parameter int CH_BITS = $clog2(NUM_CH + 1),   // Channel number width
  parameter int MAX_N   = 64,                   // Max matrix size
  parameter int N_BITS  = $clog2(MAX_N + 1)     // mat_size and coordinate width
)(
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,      // Freeze all counters
  input  logic               cmd_valid,  // New block offered
  input  logic [N_BITS-1:0]  mat_size,   // Dot product length 3..MAX_N
  input  logic [N_BITS-1:0]  pos_row,    // Base row of the block
  input  logic [N_BITS-1:0]  pos_col,    // Base column of the block
  input  logic [CH_BITS-1:0] channel,    // Channel of the block
  output logic               cmd_ready,
  output logic               idle,       // No PE active
  sta_result_if.coordinator  res
);

  // Counter holds up to ceil(MAX_N/4)
  localparam int CT_BITS = $clog2((MAX_N + 3) / 4 + 1);

  logic [N_BITS:0]    size_up;         // One spare bit for the round-up
  logic [CT_BITS-1:0] compute_cycles;  // ceil(mat_size/4)
  logic               accept;

  // Per-PE state
  logic               active   [ROWS][COLS];
  logic               first    [ROWS][COLS];  // First compute cycle of a block
  logic [CT_BITS-1:0] cnt      [ROWS][COLS];  // Zero on the last cycle
  logic [N_BITS-1:0]  base_row [ROWS][COLS];
  logic [N_BITS-1:0]  base_col [ROWS][COLS];
  logic [CH_BITS-1:0] ch       [ROWS][COLS];

  // Per-PE load request and the values it takes
  logic               load   [ROWS][COLS];
  logic [CT_BITS-1:0] ld_cnt [ROWS][COLS];
  logic [N_BITS-1:0]  ld_row [ROWS][COLS];
  logic [N_BITS-1:0]  ld_col [ROWS][COLS];
  logic [CH_BITS-1:0] ld_ch  [ROWS][COLS];

  assign size_up        = {1'b0, mat_size} + (N_BITS + 1)'(3);
  assign compute_cycles = CT_BITS'(size_up >> 2);

  // PE(0,0) can take a new block in its final cycle
  assign cmd_ready = !active[0][0] || (cnt[0][0] == '0);
  assign accept    = cmd_valid && cmd_ready && !stall;

  for (genvar i = 0; i < ROWS; i++) begin : g_row
    for (genvar j = 0; j < COLS; j++) begin : g_col

      if (i == 0 && j == 0) begin : g_origin
        assign load[i][j]   = accept;
        assign ld_cnt[i][j] = compute_cycles - 1'b1;
        assign ld_row[i][j] = pos_row;
        assign ld_col[i][j] = pos_col;
        assign ld_ch[i][j]  = channel;
      end else if (j == 0) begin : g_from_north
        // Column 0 follows the PE above one cycle later
        assign load[i][j]   = first[i-1][j];
        assign ld_cnt[i][j] = cnt[i-1][j];  // Still C-1 on its first cycle
        assign ld_row[i][j] = base_row[i-1][j];
        assign ld_col[i][j] = base_col[i-1][j];
        assign ld_ch[i][j]  = ch[i-1][j];
      end else begin : g_from_west
        assign load[i][j]   = first[i][j-1];
        assign ld_cnt[i][j] = cnt[i][j-1];
        assign ld_row[i][j] = base_row[i][j-1];
        assign ld_col[i][j] = base_col[i][j-1];
        assign ld_ch[i][j]  = ch[i][j-1];
      end

      always_ff @(posedge clk) begin
        if (reset) begin
          active[i][j] <= 1'b0;
          first[i][j]  <= 1'b0;
          cnt[i][j]    <= '0;
        end else if (!stall) begin
          first[i][j] <= load[i][j];
          if (active[i][j]) begin
            if (cnt[i][j] != '0) begin
              cnt[i][j] <= cnt[i][j] - 1'b1;
            end else begin
              active[i][j] <= 1'b0;  // Retire after the valid cycle
            end
          end
          // A new block may land on the old block's last cycle
          if (load[i][j]) begin
            active[i][j] <= 1'b1;
            cnt[i][j]    <= ld_cnt[i][j];
          end
        end
      end

      // Block tags travel with the count through the grid
      always_ff @(posedge clk) begin
        if (!stall && load[i][j]) begin
          base_row[i][j] <= ld_row[i][j];
          base_col[i][j] <= ld_col[i][j];
          ch[i][j]       <= ld_ch[i][j];
        end
      end

      assign res.valid[i*COLS+j]   = active[i][j] && (cnt[i][j] == '0);
      assign res.row[i*COLS+j]     = base_row[i][j] + N_BITS'(i);  // Offset from PE(0,0)
      assign res.col[i*COLS+j]     = base_col[i][j] + N_BITS'(j);
      assign res.channel[i*COLS+j] = ch[i][j];
    end
  end

  // Idle only once every PE has retired
  always_comb begin
    idle = 1'b1;
    for (int i = 0; i < ROWS; i++) begin
      for (int j = 0; j < COLS; j++) begin
        if (active[i][j]) begin
          idle = 1'b0;
        end
      end
    end
  end

endmodule

// ==== logic/sta_array.sv ====
module sta_array
  import sta_pkg::*;
#(
  parameter int ROWS = 4,  // PE rows
  parameter int COLS = 4   // PE columns
)(
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,         // Global freeze
  input  opnd_pack_t west [ROWS],   // Skewed packs entering column 0
  input  opnd_pack_t north [COLS],  // Skewed packs entering row 0
  sta_result_if.array res           // Last flags in, data out
);

  // Forwarded operands leaving each PE
  opnd_pack_t a_fwd [ROWS][COLS];
  opnd_pack_t b_fwd [ROWS][COLS];

  // Operands arriving at each PE
  opnd_pack_t a_pe [ROWS][COLS];
  opnd_pack_t b_pe [ROWS][COLS];

  for (genvar i = 0; i < ROWS; i++) begin : g_row
    for (genvar j = 0; j < COLS; j++) begin : g_col

      // West edge takes the skew buffer, others the left neighbor
      if (j == 0) begin : g_a_edge
        assign a_pe[i][j] = west[i];
      end else begin : g_a_inner
        assign a_pe[i][j] = a_fwd[i][j-1];
      end

      // North edge likewise
      if (i == 0) begin : g_b_edge
        assign b_pe[i][j] = north[j];
      end else begin : g_b_inner
        assign b_pe[i][j] = b_fwd[i-1][j];
      end

      sta_pe u_pe (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .last   (res.valid[i*COLS+j]),  // Valid marks the final MAC cycle
        .a_in   (a_pe[i][j]),
        .b_in   (b_pe[i][j]),
        .a_out  (a_fwd[i][j]),
        .b_out  (b_fwd[i][j]),
        .result (res.data[i*COLS+j])
      );
    end
  end

endmodule

// ==== logic/sta_pe.sv ====
module sta_pe
  import sta_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,   // Freeze accumulator and forwarding
  input  logic       last,    // Final compute cycle of the current block
  input  opnd_pack_t a_in,    // From west neighbor or skew buffer
  input  opnd_pack_t b_in,    // From north neighbor or skew buffer
  output opnd_pack_t a_out,   // To east neighbor
  output opnd_pack_t b_out,   // To south neighbor
  output acc_t       result   // Running sum including this cycle's products
);

  acc_t acc;      // Sum of all earlier packs of the block
  acc_t mac_sum;  // Four lane products of this cycle

  // Four signed 8x8 multiplies, summed
  always_comb begin
    operand_t                   a_lane;
    operand_t                   b_lane;
    logic signed [2*DATA_W-1:0] prod;

    mac_sum = '0;
    for (int l = 0; l < LANES; l++) begin
      a_lane  = a_in[l*DATA_W +: DATA_W];
      b_lane  = b_in[l*DATA_W +: DATA_W];
      prod    = a_lane * b_lane;  // Full 16-bit signed product
      mac_sum = mac_sum + prod;   // Sign-extends into the sum
    end
  end

  // Valid result on the last cycle needs no extra register stage
  assign result = acc + mac_sum;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc   <= '0;
      a_out <= '0;
      b_out <= '0;
    end else if (!stall) begin
      a_out <= a_in;  // One hop east
      b_out <= b_in;  // One hop south
      if (last) begin
        acc <= '0;  // Next block starts from zero
      end else begin
        acc <= result;
      end
    end
  end

endmodule

// ==== logic/sta_pkg.sv ====
package sta_pkg;

  // Lanes per operand pack, one MAC lane each
  parameter int LANES = 4;

  // Operand width in bits
  parameter int DATA_W = 8;

  // Accumulator width, wide enough for long dot products
  parameter int ACC_W = 32;

  // One signed operand
  typedef logic signed [DATA_W-1:0] operand_t;

  // Four operands side by side
  // Lane 0 sits in the low byte, lane 3 in the high byte
  typedef logic [LANES*DATA_W-1:0] opnd_pack_t;

  // Accumulated dot product of one PE
  typedef logic signed [ACC_W-1:0] acc_t;

endpackage

// ==== logic/sta_result_if.sv ====
interface sta_result_if
  import sta_pkg::*;
#(
  parameter int ROWS    = 4,  // PE rows
  parameter int COLS    = 4,  // PE columns
  parameter int N_BITS  = 7,  // Width of coordinates
  parameter int CH_BITS = 5   // Width of channel number
);

  // One entry per PE, flat index row*COLS + col
  logic                valid   [ROWS*COLS];  // Result complete this cycle
  logic [N_BITS-1:0]   row     [ROWS*COLS];  // Absolute output row
  logic [N_BITS-1:0]   col     [ROWS*COLS];  // Absolute output column
  logic [CH_BITS-1:0]  channel [ROWS*COLS];  // Output channel
  acc_t                data    [ROWS*COLS];  // Dot product from the PE

  // Tags and valids come from the coordinator
  modport coordinator (
    output valid,
    output row,
    output col,
    output channel
  );

  // Array uses valid as each PE's last-cycle flag and returns data
  modport array (
    input  valid,
    output data
  );

endinterface

// ==== logic/sta_top.sv ====
module sta_top
  import sta_pkg::*;
#(
  parameter  int ROWS    = 4,                   // PE rows
  parameter  int COLS    = 4,                   // PE columns
  parameter  int NUM_CH  = 16,                  // Max channel count
  parameter  int MAX_N   = 64,                  // Max matrix size
  localparam int CH_BITS = $clog2(NUM_CH + 1),
  localparam int N_BITS  = $clog2(MAX_N + 1)
)(
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,                   // Global freeze
  input  logic               cmd_valid,
  input  logic [N_BITS-1:0]  mat_size,
  input  logic [N_BITS-1:0]  pos_row,
  input  logic [N_BITS-1:0]  pos_col,
  input  logic [CH_BITS-1:0] channel,
  input  opnd_pack_t         west_in     [ROWS],      // Unskewed row packs
  input  opnd_pack_t         north_in    [COLS],      // Unskewed column packs
  output logic               cmd_ready,
  output logic               idle,
  output logic               res_valid   [ROWS*COLS], // Flat index row*COLS + col
  output logic [N_BITS-1:0]  res_row     [ROWS*COLS],
  output logic [N_BITS-1:0]  res_col     [ROWS*COLS],
  output logic [CH_BITS-1:0] res_channel [ROWS*COLS],
  output acc_t               res_data    [ROWS*COLS]
);

  opnd_pack_t west_skewed  [ROWS];
  opnd_pack_t north_skewed [COLS];

  sta_result_if #(
    .ROWS    (ROWS),
    .COLS    (COLS),
    .N_BITS  (N_BITS),
    .CH_BITS (CH_BITS)
  ) res_bus ();

  operand_skew #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) u_skew (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .west_in   (west_in),
    .north_in  (north_in),
    .west_out  (west_skewed),
    .north_out (north_skewed)
  );

  output_coordinator #(
    .ROWS    (ROWS),
    .COLS    (COLS),
    .NUM_CH  (NUM_CH),
    .CH_BITS (CH_BITS),
    .MAX_N   (MAX_N),
    .N_BITS  (N_BITS)
  ) u_coord (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .cmd_valid (cmd_valid),
    .mat_size  (mat_size),
    .pos_row   (pos_row),
    .pos_col   (pos_col),
    .channel   (channel),
    .cmd_ready (cmd_ready),
    .idle      (idle),
    .res       (res_bus.coordinator)
  );

  sta_array #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) u_array (
    .clk   (clk),
    .reset (reset),
    .stall (stall),
    .west  (west_skewed),
    .north (north_skewed),
    .res   (res_bus.array)
  );

  // Result bundle out to plain ports
  assign res_valid   = res_bus.valid;
  assign res_row     = res_bus.row;
  assign res_col     = res_bus.col;
  assign res_channel = res_bus.channel;
  assign res_data    = res_bus.data;

endmodule
